// File: design/bm_pkg.sv
package bm_pkg;

    // ------------------------------
    // buffer geometry
    // ------------------------------
    localparam int FM_AW        = 10;               // feature-map buffer address bits
    localparam int FM_DEPTH     = 1 << FM_AW;       // 1024 words per fm buffer

    localparam int FILTER_AW    = 9;                // up to 512 input channels
    localparam int FILTER_DEPTH = 1 << FILTER_AW;

    localparam int NUM_FILTERS  = 4;                // filters per load, one byte lane each
    localparam int KERNEL_TAPS  = 9;                // 3x3 kernel

    // ------------------------------
    // word types
    // ------------------------------
    // four 8-bit channels per fm word
    typedef logic [8*NUM_FILTERS-1:0] fm_word_t;

    // tap k sits at byte k
    typedef logic [8*KERNEL_TAPS-1:0] filter_word_t;

    typedef logic [31:0] axi_word_t;                // streamed input word

    typedef logic [FM_AW-1:0]     fm_addr_t;
    typedef logic [FILTER_AW-1:0] filter_addr_t;

    // ------------------------------
    // ping-pong roles
    // ------------------------------
    typedef enum logic {
        ROLE_IFM = 1'b0,    // read by the PE array, target of IFM loads
        ROLE_OFM = 1'b1     // receives OFM writes
    } fm_role_t;

endpackage

// File: design/layer_pkg.sv
package layer_pkg;

    localparam int NUM_LAYERS = 11;

    typedef logic [4:0] layer_idx_t;

    // input channels per conv layer
    function automatic logic [9:0] cin_for_layer(input layer_idx_t idx);
        logic [9:0] cin;
        cin = 10'd0;
        if (idx < layer_idx_t'(NUM_LAYERS)) begin
            case (idx)
                5'd0:    cin = 10'd3;      // rgb input
                5'd1:    cin = 10'd16;
                5'd2:    cin = 10'd32;
                5'd3:    cin = 10'd64;
                5'd4:    cin = 10'd128;
                5'd5:    cin = 10'd256;
                5'd6:    cin = 10'd512;    // widest layer, fills the filter buffer
                5'd7:    cin = 10'd256;
                5'd8:    cin = 10'd512;
                5'd9:    cin = 10'd128;
                5'd10:   cin = 10'd384;    // concat of two branches
                default: cin = 10'd0;
            endcase
        end
        return cin;
    endfunction

endpackage

// File: design/dual_port_ram.sv
`timescale 1ns/1ns

module dual_port_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 1024,
    parameter int  AW        = 10
) (
    input  logic          clk,
    // write port
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  payload_t      wdata,
    // read port, one cycle latency
    input  logic          re,
    input  logic [AW-1:0] raddr,
    output payload_t      rdata
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];    // holds while re is low
        end
    end

    // out-of-range access would alias in a smaller macro
    a_waddr_range: assert property (@(posedge clk) we |-> (waddr < DEPTH))
        else $error("dual_port_ram: write address %0d beyond depth", waddr);
    a_raddr_range: assert property (@(posedge clk) re |-> (raddr < DEPTH))
        else $error("dual_port_ram: read address %0d beyond depth", raddr);

endmodule

// File: design/filter_packer.sv
`timescale 1ns/1ns

module filter_packer
    import bm_pkg::*;
    import layer_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  layer_idx_t   q_layer,
    input  logic         q_load_filter,
    input  logic         first,           // first word of a burst
    input  axi_word_t    read_data,
    input  logic         read_data_vld,
    output logic         load_done,
    // PE array side
    input  logic         fb_req,
    input  filter_addr_t fb_addr,
    output filter_word_t fb_data0,
    output filter_word_t fb_data1,
    output filter_word_t fb_data2,
    output filter_word_t fb_data3
);

    logic         f_vld;                  // word belongs to the filter load
    logic         f_start;                // burst restart
    logic [3:0]   tap_cnt;                // next tap, 0..8
    logic [3:0]   cur_tap;                // tap of the current word
    logic         kernel_last;            // ninth word of a kernel
    filter_addr_t last_addr;              // last channel of the layer
    logic         wr_en;
    filter_addr_t wr_addr;                // channel address
    logic         done_r;
    logic         done_d;
    filter_word_t acc     [NUM_FILTERS];  // kernels under assembly
    filter_word_t wr_data [NUM_FILTERS];
    filter_word_t rd_data [NUM_FILTERS];

    assign f_vld       = q_load_filter & read_data_vld;
    assign f_start     = f_vld & first;
    assign cur_tap     = first ? 4'd0 : tap_cnt;  // first word is always tap 0
    assign kernel_last = f_vld && (cur_tap == 4'(KERNEL_TAPS - 1));
    assign last_addr   = filter_addr_t'(cin_for_layer(q_layer) - 10'd1);

    // ------------------------------
    // tap counter
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tap_cnt <= 4'd0;
        end else if (f_vld) begin
            tap_cnt <= kernel_last ? 4'd0 : cur_tap + 4'd1;
        end
    end

    // byte n of each word -> filter n, tap k at bits 8k up
    always_ff @(posedge clk) begin
        for (int n = 0; n < NUM_FILTERS; n++) begin
            if (f_vld) begin
                acc[n][8*cur_tap +: 8] <= read_data[8*n +: 8];
            end
            if (kernel_last) begin
                // taps 0..7 from acc, tap 8 straight from the bus
                wr_data[n] <= {read_data[8*n +: 8], acc[n][8*(KERNEL_TAPS-1)-1:0]};
            end
        end
    end

    // ------------------------------
    // commit, channel address, done
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
            done_r  <= 1'b0;
            done_d  <= 1'b0;
        end else begin
            wr_en  <= kernel_last;                            // write one cycle after word 9
            done_r <= kernel_last && (wr_addr == last_addr);  // lines up with the last write
            done_d <= done_r;
            if (f_start) begin
                wr_addr <= '0;
            end else if (wr_en) begin
                wr_addr <= (wr_addr == last_addr) ? '0 : wr_addr + 1'b1;  // wrap at cin
            end
        end
    end

    assign load_done = done_r & ~done_d;

    // four filter buffers, same address, one lane each
    for (genvar g = 0; g < NUM_FILTERS; g++) begin : g_fbuf
        dual_port_ram #(
            .payload_t (filter_word_t),
            .DEPTH     (FILTER_DEPTH),
            .AW        (FILTER_AW)
        ) u_fbuf (
            .clk   (clk),
            .we    (wr_en),
            .waddr (wr_addr),
            .wdata (wr_data[g]),
            .re    (fb_req),
            .raddr (fb_addr),
            .rdata (rd_data[g])
        );
    end

    assign fb_data0 = rd_data[0];
    assign fb_data1 = rd_data[1];
    assign fb_data2 = rd_data[2];
    assign fb_data3 = rd_data[3];

    a_tap_range: assert property (@(posedge clk) disable iff (!rstn)
        tap_cnt < 4'(KERNEL_TAPS))
        else $error("filter_packer: tap counter out of range");
    // raw done flag must already be a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        done_r |=> !done_r)
        else $error("filter_packer: done held for two cycles");

endmodule

// File: design/fm_ping_pong.sv
`timescale 1ns/1ns

module fm_ping_pong
    import bm_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    // streamed IFM load
    input  logic      q_load_ifm,
    input  axi_word_t read_data,
    input  logic      read_data_vld,
    input  logic      q_fm_buf_switch,  // swap IFM and OFM roles
    // IFM read port
    input  logic      ifm_rd_en,
    input  fm_addr_t  ifm_rd_addr,
    output fm_word_t  ifm_rd_data,
    // OFM write port
    input  logic      ofm_wr_en,
    input  fm_addr_t  ofm_wr_addr,
    input  fm_word_t  ofm_wr_data
);

    fm_role_t role [2];       // role of buffer 0 and 1
    logic     ifm_sel;        // index of the IFM buffer
    logic     rd_sel;         // IFM buffer at read request
    logic     load_d;
    logic     load_start;
    logic     ld_we;
    fm_addr_t ld_addr;
    fm_word_t ld_data;
    fm_word_t buf_rdata [2];

    // ------------------------------
    // role pointers
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            role[0] <= ROLE_IFM;
            role[1] <= ROLE_OFM;
        end else if (q_fm_buf_switch) begin
            role[0] <= role[1];
            role[1] <= role[0];
        end
    end

    assign ifm_sel = (role[1] == ROLE_IFM);

    // ------------------------------
    // IFM load path
    // ------------------------------
    assign load_start = q_load_ifm & ~load_d;   // rising edge of the load level

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_d  <= 1'b0;
            ld_we   <= 1'b0;
            ld_addr <= '0;
            rd_sel  <= 1'b0;
        end else begin
            load_d <= q_load_ifm;
            ld_we  <= q_load_ifm & read_data_vld;
            if (load_start) begin
                ld_addr <= '0;
            end else if (ld_we) begin
                ld_addr <= ld_addr + 1'b1;      // sequential fill
            end
            if (ifm_rd_en) begin
                rd_sel <= ifm_sel;              // follows the data, not the role
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_data_vld) begin
            ld_data <= read_data;
        end
    end

    // IFM buffer takes loads and reads, OFM buffer takes writes
    for (genvar b = 0; b < 2; b++) begin : g_fmbuf
        logic is_ifm;
        assign is_ifm = (role[b] == ROLE_IFM);

        dual_port_ram #(
            .payload_t (fm_word_t),
            .DEPTH     (FM_DEPTH),
            .AW        (FM_AW)
        ) u_fmbuf (
            .clk   (clk),
            .we    (is_ifm ? ld_we   : ofm_wr_en),
            .waddr (is_ifm ? ld_addr : ofm_wr_addr),
            .wdata (is_ifm ? ld_data : ofm_wr_data),
            .re    (is_ifm & ifm_rd_en),
            .raddr (ifm_rd_addr),
            .rdata (buf_rdata[b])
        );
    end

    assign ifm_rd_data = buf_rdata[rd_sel];

    a_no_ofm_in_load: assert property (@(posedge clk) disable iff (!rstn)
        q_load_ifm |-> !ofm_wr_en)
        else $error("fm_ping_pong: OFM write during IFM load");
    // a swap mid-load would split the IFM across both buffers
    a_no_switch_in_load: assert property (@(posedge clk) disable iff (!rstn)
        q_load_ifm |-> !q_fm_buf_switch)
        else $error("fm_ping_pong: buffer switch during IFM load");

endmodule

// File: design/buffer_manager.sv
`timescale 1ns/1ns

module buffer_manager
    import bm_pkg::*;
    import layer_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    // layer and load control
    input  layer_idx_t   q_layer,
    input  logic         q_load_filter,
    input  logic         first,
    input  logic         q_load_ifm,
    input  logic         q_fm_buf_switch,
    output logic         o_load_filter_done,
    // stream in, shared by both loads
    input  axi_word_t    read_data,
    input  logic         read_data_vld,
    // filter read toward PE array
    input  logic         fb_req,
    input  filter_addr_t fb_addr,
    output filter_word_t fb_data0_out,
    output filter_word_t fb_data1_out,
    output filter_word_t fb_data2_out,
    output filter_word_t fb_data3_out,
    // feature-map ports
    input  logic         ifm_rd_en,
    input  fm_addr_t     ifm_rd_addr,
    output fm_word_t     ifm_rd_data,
    input  logic         ofm_wr_en,
    input  fm_addr_t     ofm_wr_addr,
    input  fm_word_t     ofm_wr_data
);

    // ------------------------------
    // filter section
    // ------------------------------
    filter_packer u_filter_packer (
        .clk           (clk),
        .rstn          (rstn),
        .q_layer       (q_layer),
        .q_load_filter (q_load_filter),
        .first         (first),
        .read_data     (read_data),
        .read_data_vld (read_data_vld),     // gated inside by q_load_filter
        .load_done     (o_load_filter_done),
        .fb_req        (fb_req),
        .fb_addr       (fb_addr),
        .fb_data0      (fb_data0_out),
        .fb_data1      (fb_data1_out),
        .fb_data2      (fb_data2_out),
        .fb_data3      (fb_data3_out)
    );

    // ------------------------------
    // feature-map section
    // ------------------------------
    fm_ping_pong u_fm_ping_pong (
        .clk             (clk),
        .rstn            (rstn),
        .q_load_ifm      (q_load_ifm),
        .read_data       (read_data),
        .read_data_vld   (read_data_vld),   // gated inside by q_load_ifm
        .q_fm_buf_switch (q_fm_buf_switch),
        .ifm_rd_en       (ifm_rd_en),
        .ifm_rd_addr     (ifm_rd_addr),
        .ifm_rd_data     (ifm_rd_data),
        .ofm_wr_en       (ofm_wr_en),
        .ofm_wr_addr     (ofm_wr_addr),
        .ofm_wr_data     (ofm_wr_data)
    );

endmodule

// File: testbench/tb_buffer_manager.sv
`timescale 1ns/1ns

module tb_buffer_manager
    import bm_pkg::*;
    import layer_pkg::*;
();

    localparam int TOTAL_WORDS = 489;   // stream words plus readbacks, all tests

    logic         clk;
    logic         rstn;
    layer_idx_t   q_layer;
    logic         q_load_filter;
    logic         first;
    logic         q_load_ifm;
    logic         q_fm_buf_switch;
    logic         o_load_filter_done;
    axi_word_t    read_data;
    logic         read_data_vld;
    logic         fb_req;
    filter_addr_t fb_addr;
    filter_word_t fb_data0;
    filter_word_t fb_data1;
    filter_word_t fb_data2;
    filter_word_t fb_data3;
    logic         ifm_rd_en;
    fm_addr_t     ifm_rd_addr;
    fm_word_t     ifm_rd_data;
    logic         ofm_wr_en;
    fm_addr_t     ofm_wr_addr;
    fm_word_t     ofm_wr_data;

    int           seed = 32'hf0bf_65d3;
    int           done_cnt;
    filter_word_t exp_f [NUM_FILTERS][16];  // model kernels, [filter][channel]
    fm_word_t     exp_ifm [64];
    fm_word_t     exp_ofm [32];

    buffer_manager u_buffer_manager (
        .clk (clk), .rstn (rstn), .q_layer (q_layer),
        .q_load_filter (q_load_filter), .first (first), .q_load_ifm (q_load_ifm),
        .q_fm_buf_switch (q_fm_buf_switch), .o_load_filter_done (o_load_filter_done),
        .read_data (read_data), .read_data_vld (read_data_vld),
        .fb_req (fb_req), .fb_addr (fb_addr),
        .fb_data0_out (fb_data0), .fb_data1_out (fb_data1),
        .fb_data2_out (fb_data2), .fb_data3_out (fb_data3),
        .ifm_rd_en (ifm_rd_en), .ifm_rd_addr (ifm_rd_addr), .ifm_rd_data (ifm_rd_data),
        .ofm_wr_en (ofm_wr_en), .ofm_wr_addr (ofm_wr_addr), .ofm_wr_data (ofm_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (o_load_filter_done) done_cnt++;     // outputs settled mid-cycle
    end

    // ------------------------------
    // checks
    // ------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_filter(input string name, input filter_word_t exp,
                                input filter_word_t act);
        if (act !== exp) abort_run($sformatf("ERR %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_fm(input string name, input fm_word_t exp, input fm_word_t act);
        if (act !== exp) abort_run($sformatf("ERR %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_done_once(input string name);
        if (done_cnt != 1) abort_run($sformatf("%s: load done pulsed %0d times instead of once",
                                               name, done_cnt));
    endtask

    // ------------------------------
    // drivers
    // ------------------------------
    task automatic stream_filter(input int nwords, input bit gaps);
        axi_word_t w;
        q_load_filter = 1'b1;
        for (int i = 0; i < nwords; i++) begin
            read_data_vld = 1'b0;
            first         = 1'b0;
            if (gaps) repeat ($random(seed) & 3) @(negedge clk);  // idle gap
            w             = $random(seed);
            read_data     = w;
            read_data_vld = 1'b1;
            first         = (i == 0);
            for (int n = 0; n < NUM_FILTERS; n++) begin
                // byte n -> filter n, tap k at bits 8k up
                exp_f[n][i / KERNEL_TAPS][8*(i % KERNEL_TAPS) +: 8] = w[8*n +: 8];
            end
            @(negedge clk);
        end
        read_data_vld = 1'b0;
        first         = 1'b0;
        q_load_filter = 1'b0;
        repeat (2) @(negedge clk);              // commit lands one cycle after word 9
    endtask

    task automatic read_filters(input string name, input int nch);
        for (int c = 0; c < nch; c++) begin
            fb_req  = 1'b1;
            fb_addr = filter_addr_t'(c);
            @(negedge clk);
            check_filter(name, exp_f[0][c], fb_data0);
            check_filter(name, exp_f[1][c], fb_data1);
            check_filter(name, exp_f[2][c], fb_data2);
            check_filter(name, exp_f[3][c], fb_data3);
        end
        fb_req = 1'b0;
    endtask

    task automatic read_ifm(input string name, input int nwords, input bit from_ofm);
        for (int a = 0; a < nwords; a++) begin
            ifm_rd_en   = 1'b1;
            ifm_rd_addr = fm_addr_t'(a);
            @(negedge clk);
            check_fm(name, from_ofm ? exp_ofm[a] : exp_ifm[a], ifm_rd_data);
        end
        ifm_rd_en = 1'b0;
    endtask

    task automatic pulse_switch();
        q_fm_buf_switch = 1'b1;
        @(negedge clk);
        q_fm_buf_switch = 1'b0;
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic test_filter_layer0();
        q_layer  = 5'd0;                        // 3 channels
        done_cnt = 0;
        stream_filter(27, 1'b0);
        check_done_once("test_filter_layer0");
        read_filters("test_filter_layer0", 3);
    endtask

    task automatic test_filter_gaps();
        q_layer  = 5'd1;                        // 16 channels
        done_cnt = 0;
        stream_filter(16 * KERNEL_TAPS, 1'b1);
        check_done_once("test_filter_gaps");
        read_filters("test_filter_gaps", 16);
    endtask

    task automatic test_ifm_load();
        q_load_ifm = 1'b1;
        for (int i = 0; i < 64; i++) begin
            exp_ifm[i]    = $random(seed);
            read_data     = exp_ifm[i];
            read_data_vld = 1'b1;
            @(negedge clk);
        end
        read_data_vld = 1'b0;
        q_load_ifm    = 1'b0;
        repeat (2) @(negedge clk);
        read_ifm("test_ifm_load", 64, 1'b0);
    endtask

    task automatic test_ofm_switch();
        for (int a = 0; a < 32; a++) begin
            exp_ofm[a]  = $random(seed);
            ofm_wr_en   = 1'b1;                 // goes to buffer 1, OFM after reset
            ofm_wr_addr = fm_addr_t'(a);
            ofm_wr_data = exp_ofm[a];
            @(negedge clk);
        end
        ofm_wr_en = 1'b0;
        pulse_switch();
        read_ifm("test_ofm_switch", 32, 1'b1);
        pulse_switch();                         // back to the loaded ifm
        read_ifm("test_ofm_switch", 64, 1'b0);
    endtask

    task automatic test_filter_reload();
        q_layer  = 5'd0;
        done_cnt = 0;
        stream_filter(13, 1'b0);                // stops at channel 1, tap 4
        stream_filter(27, 1'b0);                // fresh burst overwrites the model
        check_done_once("test_filter_reload");
        read_filters("test_filter_reload", 3);
    endtask

    initial begin
        repeat (TOTAL_WORDS * 4 + 200) @(posedge clk);
        abort_run("timeout: the tests did not finish in the expected number of cycles");
    end

    initial begin
        rstn            = 1'b0;
        q_layer         = '0;
        q_load_filter   = 1'b0;
        first           = 1'b0;
        q_load_ifm      = 1'b0;
        q_fm_buf_switch = 1'b0;
        read_data       = '0;
        read_data_vld   = 1'b0;
        fb_req          = 1'b0;
        fb_addr         = '0;
        ifm_rd_en       = 1'b0;
        ifm_rd_addr     = '0;
        ofm_wr_en       = 1'b0;
        ofm_wr_addr     = '0;
        ofm_wr_data     = '0;
        done_cnt        = 0;
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        test_filter_layer0();
        test_filter_gaps();
        test_ifm_load();
        test_ofm_switch();
        test_filter_reload();
        $display("test passed");
        $finish;
    end

endmodule

// File: tb.f
design/bm_pkg.sv
design/layer_pkg.sv
design/dual_port_ram.sv
design/filter_packer.sv
design/fm_ping_pong.sv
design/buffer_manager.sv
testbench/tb_buffer_manager.sv
